//--- hdl/timer_pkg.sv
// shared widths, constants and the timer state enum
// used by the countdown timer RTL and its testbench

package timer_pkg;

    // display and time widths
    localparam int unsigned TIME_WIDTH  = 4;  // one bit per LED
    localparam int unsigned FLASH_WIDTH = 3;  // holds FLASH_SECONDS

    // time left in seconds and also the LED pattern
    typedef logic [TIME_WIDTH-1:0] time_value_t;

    // flashing seconds still to go
    typedef logic [FLASH_WIDTH-1:0] flash_count_t;

    // timer FSM states
    typedef enum logic [2:0] {
        IDLE,       // waits for control press
        INIT,       // loads default time and flash count
        SET_TIME,   // shifts in entry bits
        COUNTDOWN,  // decrements once per second
        DONE        // flashes all LEDs
    } timer_state_t;

    // time loaded when the timer starts
    localparam time_value_t DEFAULT_TIME = 4'b1000;

    // seconds spent flashing once zero is reached
    localparam flash_count_t FLASH_SECONDS = 3'd4;

    // synchronizer depth for the button inputs
    localparam int unsigned SYNC_STAGES = 2;

endpackage

//--- hdl/timer_status_if.sv
// timer status bundle from the control FSM to the LED driver

interface timer_status_if;

    timer_pkg::time_value_t  time_left;    // seconds remaining
    timer_pkg::timer_state_t state;        // current FSM state
    logic                    flash_phase;  // flash on/off level
    logic                    tick;         // one-second pulse

    // control side owns the whole bundle
    modport control (
        output time_left,
        output state,
        output flash_phase,
        output tick
    );

    // display side only looks
    modport display (
        input time_left,
        input state,
        input flash_phase,
        input tick
    );

endinterface

//--- hdl/button_debounce.sv
// button synchronizer and debouncer
// one-cycle pulse on a debounced release

module button_debounce #(
    parameter int unsigned DEBOUNCE_CYCLES = 1_000_000
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic button,
    output      logic released
);

    localparam int unsigned SYNC_W = timer_pkg::SYNC_STAGES;
    localparam int unsigned CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);

    // counter value on the last differing sample
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [SYNC_W-1:0] sync_q;  // synchronizer chain
    logic              sync_in;
    logic              level;   // debounced button level
    logic [CNT_W-1:0]  cnt;     // run length of differing samples

    assign sync_in = sync_q[SYNC_W-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q   <= '0;
            level    <= 1'b0;
            cnt      <= '0;
            released <= 1'b0;
        end else begin
            sync_q   <= {sync_q[SYNC_W-2:0], button};
            released <= 1'b0;

            if (sync_in == level) begin
                cnt <= '0;  // glitch over so the run starts again
            end else if (cnt == CNT_LAST) begin
                // input held long enough to accept the new level
                level    <= sync_in;
                cnt      <= '0;
                released <= level;  // only on high to low
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- hdl/tick_generator.sv
// one-second tick divider and flash phase generator

module tick_generator #(
    parameter int unsigned TICK_DIVIDER = 100_000_000
) (
    input  wire logic clk,
    input  wire logic reset,
    output      logic tick,
    output      logic flash_phase
);

    localparam int unsigned CNT_W = $clog2(TICK_DIVIDER);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIVIDER - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(TICK_DIVIDER / 2 - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt         <= '0;
            tick        <= 1'b0;
            flash_phase <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (cnt == CNT_LAST) begin
                cnt  <= '0;
                tick <= 1'b1;  // one second gone at wrap
            end else begin
                cnt <= cnt + 1'b1;
            end

            // toggle at mid period and at wrap
            if (cnt == CNT_LAST || cnt == CNT_HALF) begin
                flash_phase <= ~flash_phase;
            end
        end
    end

endmodule

//--- hdl/countdown_control.sv
// countdown timer FSM with time entry, countdown and flash duration
// drives the status bundle for the LED driver

module countdown_control (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       start_stop,
    input  wire logic       enter_zero,
    input  wire logic       enter_one,
    input  wire logic       tick,
    input  wire logic       flash_phase,
    timer_status_if.control status
);

    timer_pkg::timer_state_t state;
    timer_pkg::timer_state_t state_next;
    timer_pkg::time_value_t  time_left;
    timer_pkg::flash_count_t flash_cnt;  // flash seconds left

    // next state
    always_comb begin
        state_next = state;
        case (state)
            timer_pkg::IDLE: begin
                if (start_stop) begin
                    state_next = timer_pkg::INIT;
                end
            end
            timer_pkg::INIT: begin
                state_next = timer_pkg::SET_TIME;
            end
            timer_pkg::SET_TIME: begin
                if (start_stop) begin
                    state_next = timer_pkg::COUNTDOWN;
                end
            end
            timer_pkg::COUNTDOWN: begin
                // also catches a zero typed in by the user
                if (time_left == '0) begin
                    state_next = timer_pkg::DONE;
                end
            end
            timer_pkg::DONE: begin
                if (flash_cnt == '0) begin
                    state_next = timer_pkg::IDLE;
                end
            end
            default: begin
                state_next = timer_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= timer_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // time and flash counters
    always_ff @(posedge clk) begin
        if (reset) begin
            time_left <= '0;
            flash_cnt <= '0;
        end else begin
            case (state)
                timer_pkg::INIT: begin
                    time_left <= timer_pkg::DEFAULT_TIME;
                    flash_cnt <= timer_pkg::FLASH_SECONDS;
                end
                timer_pkg::SET_TIME: begin
                    if (enter_zero) begin
                        time_left <= {time_left[2:0], 1'b0};  // zero wins a tie
                    end else if (enter_one) begin
                        time_left <= {time_left[2:0], 1'b1};
                    end
                end
                timer_pkg::COUNTDOWN: begin
                    if (tick && time_left != '0) begin
                        time_left <= time_left - 1'b1;
                    end
                end
                timer_pkg::DONE: begin
                    if (tick && flash_cnt != '0) begin
                        flash_cnt <= flash_cnt - 1'b1;
                    end
                end
                default: begin
                    // button pulses dropped in IDLE
                end
            endcase
        end
    end

    // status out with tick and phase passed straight through
    assign status.state       = state;
    assign status.time_left   = time_left;
    assign status.tick        = tick;
    assign status.flash_phase = flash_phase;

endmodule

//--- hdl/led_output.sv
// LED pattern select from timer state, time left and flash phase

module led_output (
    timer_status_if.display        status,
    output timer_pkg::time_value_t led
);

    localparam int unsigned LED_W = $bits(timer_pkg::time_value_t);

    always_comb begin
        case (status.state)
            timer_pkg::SET_TIME,
            timer_pkg::COUNTDOWN: begin
                led = status.time_left;  // show seconds left
            end
            timer_pkg::DONE: begin
                // all LEDs blink together
                led = {LED_W{status.flash_phase}};
            end
            default: begin
                led = '0;  // dark in IDLE and INIT
            end
        endcase
    end

endmodule

//--- hdl/countdown_timer_top.sv
// countdown timer top level
// three button debouncers, tick divider, control FSM and LED driver

module countdown_timer_top #(
    parameter int unsigned TICK_DIVIDER    = 100_000_000,  // 1 s at 100 MHz
    parameter int unsigned DEBOUNCE_CYCLES = 1_000_000     // 10 ms at 100 MHz
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   btn_ctrl,
    input  wire logic                   btn_0,
    input  wire logic                   btn_1,
    output      timer_pkg::time_value_t led
);

    logic sig_ctrl;  // release pulses
    logic sig_0;
    logic sig_1;
    logic tick;
    logic flash_phase;

    timer_status_if status ();

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_ctrl (
        .clk      (clk),
        .reset    (reset),
        .button   (btn_ctrl),
        .released (sig_ctrl)
    );

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_0 (
        .clk      (clk),
        .reset    (reset),
        .button   (btn_0),
        .released (sig_0)
    );

    button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_1 (
        .clk      (clk),
        .reset    (reset),
        .button   (btn_1),
        .released (sig_1)
    );

    tick_generator #(.TICK_DIVIDER(TICK_DIVIDER)) tick_gen_i (
        .clk         (clk),
        .reset       (reset),
        .tick        (tick),
        .flash_phase (flash_phase)
    );

    countdown_control control_i (
        .clk         (clk),
        .reset       (reset),
        .start_stop  (sig_ctrl),
        .enter_zero  (sig_0),
        .enter_one   (sig_1),
        .tick        (tick),
        .flash_phase (flash_phase),
        .status      (status.control)
    );

    led_output led_i (
        .status (status.display),
        .led    (led)
    );

endmodule

//--- bench/countdown_timer_assertions.sv
// concurrent checks on the countdown control FSM
// reset state, countdown timing, INIT length and DONE exit

module countdown_timer_assertions (
    input logic                    clk,
    input logic                    reset,
    input timer_pkg::timer_state_t state,
    input timer_pkg::time_value_t  time_left,
    input logic                    tick
);

    timeunit 1ns;
    timeprecision 1ps;

    a_reset_idle: assert property (
        @(posedge clk) reset |=> state == timer_pkg::IDLE
    ) else $error("state is not IDLE after reset");

    // time only moves on a tick while counting down
    a_count_on_tick: assert property (
        @(posedge clk) disable iff (reset)
        (state == timer_pkg::COUNTDOWN && !tick) |=> $stable(time_left)
    ) else $error("time_left changed in COUNTDOWN without a tick");

    a_init_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        state == timer_pkg::INIT |=> state == timer_pkg::SET_TIME
    ) else $error("INIT lasted longer than one cycle");

    a_done_exit: assert property (
        @(posedge clk) disable iff (reset)
        state == timer_pkg::DONE |=> (state == timer_pkg::DONE || state == timer_pkg::IDLE)
    ) else $error("DONE left to a state other than IDLE");

endmodule

//--- bench/countdown_timer_tb.sv
// testbench for the countdown timer top level
// button stimulus, reference model, compare process and report

module countdown_timer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TICK_DIVIDER    = 16;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int RESET_CYCLES    = 3;
    localparam int PRESS_CYCLES    = 8;   // high time and then low time
    localparam int ENTRY_PRESSES   = 8;

    // button select
    localparam int BTN_CTRL = 0;
    localparam int BTN_ZERO = 1;
    localparam int BTN_ONE  = 2;

    // actions known to the reference model
    localparam int ACT_START = 0;
    localparam int ACT_ZERO  = 1;
    localparam int ACT_ONE   = 2;
    localparam int ACT_TICK  = 3;

    // cycle budget per test and a run limit of four times the sum
    localparam int PRESS_LEN   = 2 * PRESS_CYCLES + 1;
    localparam int T1_CYCLES   = RESET_CYCLES + 2 * TICK_DIVIDER;
    localparam int T2_CYCLES   = PRESS_LEN;
    localparam int T3_CYCLES   = (ENTRY_PRESSES + 1) * PRESS_LEN;
    localparam int T4_CYCLES   = PRESS_LEN + 15 * (TICK_DIVIDER + 2);
    localparam int T5_CYCLES   = (timer_pkg::FLASH_SECONDS + 2) * TICK_DIVIDER + PRESS_LEN;
    localparam int T6_CYCLES   = 2 * (DEBOUNCE_CYCLES + PRESS_CYCLES + 1) + PRESS_LEN;
    localparam int CYCLE_LIMIT = 4 * (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                      + T5_CYCLES + T6_CYCLES);

    logic                   clk;
    logic                   reset;
    logic                   btn_ctrl;
    logic                   btn_0;
    logic                   btn_1;
    timer_pkg::time_value_t led;

    // compare request from stimulus to the compare process
    event                   compare_ev;
    timer_pkg::time_value_t cmp_expected;
    string                  cmp_label;

    int          error_count;
    int          check_count;
    int          test_count;
    int          failed_tests;
    int          test_start_errors;
    int          cycle_count;
    logic [31:0] seed;

    countdown_timer_top #(
        .TICK_DIVIDER    (TICK_DIVIDER),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .btn_ctrl (btn_ctrl),
        .btn_0    (btn_0),
        .btn_1    (btn_1),
        .led      (led)
    );

    bind countdown_control countdown_timer_assertions assert_i (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .time_left (time_left),
        .tick      (tick)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected time value after one action
    function automatic timer_pkg::time_value_t ref_time(input int action,
                                                        input timer_pkg::time_value_t cur);
        case (action)
            ACT_START: return timer_pkg::DEFAULT_TIME;
            ACT_ZERO:  return cur << 1;  // shift in from the right
            ACT_ONE:   return (cur << 1) | 4'b0001;
            ACT_TICK:  return (cur == '0) ? cur : cur - 1'b1;
            default:   return cur;
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string label);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s, got %0d expected %0d", $time, label, actual,
                     expected);
        end
    endtask

    // compares led against the current expectation
    initial begin
        forever begin
            @(compare_ev);
            check_value(32'(led), 32'(cmp_expected), cmp_label);
        end
    end

    // caller advances at least one cycle before the next request
    task automatic expect_led(input timer_pkg::time_value_t value, input string label);
        cmp_expected = value;
        cmp_label    = label;
        -> compare_ev;
    endtask

    task automatic set_button(input int which, input logic level);
        case (which)
            BTN_CTRL: btn_ctrl = level;
            BTN_ZERO: btn_0    = level;
            default:  btn_1    = level;
        endcase
    endtask

    // held high and released long enough for the debounce
    task automatic press(input int which);
        set_button(which, 1'b1);
        repeat (PRESS_CYCLES) @(negedge clk);
        set_button(which, 1'b0);
        repeat (PRESS_CYCLES) @(negedge clk);
    endtask

    task automatic glitch(input int which, input int cycles);
        set_button(which, 1'b1);
        repeat (cycles) @(negedge clk);
        set_button(which, 1'b0);
        repeat (PRESS_CYCLES) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_count - test_start_errors;
        test_count++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %0d (%s): %0d errors", test_count, name, errs);
        test_start_errors = error_count;
    endtask

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial begin
        timer_pkg::time_value_t expected;
        timer_pkg::time_value_t countdown;
        int                     wait_cycles;
        int                     ones_runs;
        int                     high_len;
        int                     zero_run;
        int                     bad_pattern;
        int                     cycles;
        int                     act;

        btn_ctrl          = 1'b0;
        btn_0             = 1'b0;
        btn_1             = 1'b0;
        reset             = 1'b1;
        seed              = 32'd26341;
        error_count       = 0;
        check_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        expected          = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // idle stays dark
        repeat (2 * TICK_DIVIDER) begin
            expect_led('0, "led in idle");
            @(negedge clk);
        end
        finish_test("idle after reset");

        press(BTN_CTRL);
        expected = ref_time(ACT_START, expected);
        expect_led(expected, "default time after start");
        @(negedge clk);
        finish_test("start");

        for (int i = 0; i < ENTRY_PRESSES; i++) begin
            seed = lcg_next(seed);
            act  = seed[16] ? ACT_ONE : ACT_ZERO;
            press(seed[16] ? BTN_ONE : BTN_ZERO);
            expected = ref_time(act, expected);
            expect_led(expected, "entry shift");
            @(negedge clk);
        end
        if (expected == '0) begin
            // keep a countdown to watch
            press(BTN_ONE);
            expected = ref_time(ACT_ONE, expected);
            expect_led(expected, "entry shift");
            @(negedge clk);
        end
        finish_test("bit entry");

        press(BTN_CTRL);
        countdown = expected;
        while (countdown != '0) begin
            wait_cycles = 0;
            while (led == countdown && wait_cycles < TICK_DIVIDER + 2) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (led == countdown) begin
                $display("countdown stalled at %0d with no tick decrement", countdown);
                error_count++;
                break;
            end
            if (countdown != expected) begin
                // later steps are one tick period apart
                check_value(wait_cycles, TICK_DIVIDER - 1, "cycles between countdown steps");
            end
            countdown = ref_time(ACT_TICK, countdown);
            expect_led(countdown, "countdown step");
            @(negedge clk);
        end
        finish_test("countdown");

        // flash phase and then dark for good
        ones_runs   = 0;
        high_len    = 0;
        zero_run    = 0;
        bad_pattern = 0;
        cycles      = 0;
        while (zero_run <= TICK_DIVIDER && cycles < T5_CYCLES) begin
            if (led == 4'hF) begin
                if (high_len == 0) begin
                    ones_runs++;
                end
                high_len++;
                zero_run = 0;
            end else begin
                if (high_len != 0) begin
                    check_value(high_len, TICK_DIVIDER / 2, "flash on length");
                    high_len = 0;
                end
                if (led != '0) begin
                    bad_pattern++;
                end
                zero_run++;
            end
            @(negedge clk);
            cycles++;
        end
        if (zero_run <= TICK_DIVIDER) begin
            $display("led did not go dark after the flash period");
            error_count++;
        end
        check_value(ones_runs, 32'(timer_pkg::FLASH_SECONDS), "flash count");
        check_value(bad_pattern, 0, "flash pattern not all on or all off");
        press(BTN_CTRL);
        expected = ref_time(ACT_START, expected);
        expect_led(expected, "default time after restart");
        @(negedge clk);
        finish_test("flash and restart");

        glitch(BTN_ONE, DEBOUNCE_CYCLES - 1);
        expect_led(expected, "after short glitch on one");
        @(negedge clk);
        glitch(BTN_ZERO, DEBOUNCE_CYCLES - 1);
        expect_led(expected, "after short glitch on zero");
        @(negedge clk);
        press(BTN_ONE);  // a real press still works
        expected = ref_time(ACT_ONE, expected);
        expect_led(expected, "press after glitches");
        @(negedge clk);
        finish_test("glitch filter");

        $display("%0d tests, %0d with errors, %0d checks, %0d errors", test_count,
                 failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- all.f
hdl/timer_pkg.sv
hdl/timer_status_if.sv
hdl/button_debounce.sv
hdl/tick_generator.sv
hdl/countdown_control.sv
hdl/led_output.sv
hdl/countdown_timer_top.sv
bench/countdown_timer_assertions.sv
bench/countdown_timer_tb.sv

//--- run.sh
#!/bin/sh
# build and run the countdown timer testbench with Verilator
# a failed build, an aborted run or a failure line in the log fails the script

verilator --binary --timing --assert --top-module countdown_timer_tb \
    -f all.f -o countdown_timer_sim \
    && ./obj_dir/countdown_timer_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
